// ==== dv/ex_stage_tb.sv ====
`timescale 1ns/1ns
`include "ex_settings.svh"

module ex_stage_tb import ex_op_pkg::*; ();

    localparam int NUM_INSTR   = 300;
    localparam int WATCHDOG_NS = NUM_INSTR * (`EX_DIV_STEPS + 4) * 40;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    logic                 in_ready;
    logic [`EX_XLEN-1:0]  pc;
    logic [`EX_XLEN-1:0]  imm;
    logic [`EX_XLEN-1:0]  rj_value;
    logic [`EX_XLEN-1:0]  rkd_value;
    ex_unit_e             unit;
    alu_op_e              alu_op;
    mul_op_e              mul_op;
    div_op_e              div_op;
    logic                 src1_is_pc;
    logic                 src2_is_imm;
    logic [`EX_REG_W-1:0] dest;
    logic                 gr_we;
    logic                 mem_we;
    logic                 mem_load;
    logic                 out_valid;
    logic                 out_ready;
    logic [`EX_XLEN-1:0]  result_out;
    logic [`EX_XLEN-1:0]  pc_out;
    logic [`EX_XLEN-1:0]  store_data_out;
    logic [`EX_REG_W-1:0] dest_out;
    logic                 gr_we_out;
    logic                 mem_we_out;
    logic                 mem_load_out;

    integer seed = 32'h4b94a23b;
    int     issued;
    int     checked;

    // Expected outputs in program order
    logic [`EX_XLEN-1:0]  exp_result[$];
    logic [`EX_XLEN-1:0]  exp_pc[$];
    logic [`EX_XLEN-1:0]  exp_store[$];
    logic [`EX_REG_W-1:0] exp_dest[$];
    logic [2:0]           exp_flags[$];  // gr_we, mem_we, mem_load

    ex_stage u_dut (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .pc             (pc),
        .imm            (imm),
        .rj_value       (rj_value),
        .rkd_value      (rkd_value),
        .unit           (unit),
        .alu_op         (alu_op),
        .mul_op         (mul_op),
        .div_op         (div_op),
        .src1_is_pc     (src1_is_pc),
        .src2_is_imm    (src2_is_imm),
        .dest           (dest),
        .gr_we          (gr_we),
        .mem_we         (mem_we),
        .mem_load       (mem_load),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .result_out     (result_out),
        .pc_out         (pc_out),
        .store_data_out (store_data_out),
        .dest_out       (dest_out),
        .gr_we_out      (gr_we_out),
        .mem_we_out     (mem_we_out),
        .mem_load_out   (mem_load_out)
    );

    always #20 clk = ~clk;

    function automatic int rand_below(input int n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    // Corner values mixed in with plain random words
    function automatic logic [`EX_XLEN-1:0] pick_operand();
        case (rand_below(8))
            0:       pick_operand = '0;
            1:       pick_operand = '1;
            2:       pick_operand = {1'b1, {(`EX_XLEN-1){1'b0}}};
            3:       pick_operand = {1'b0, {(`EX_XLEN-1){1'b1}}};
            default: pick_operand = $random(seed);
        endcase
    endfunction

    function automatic logic [`EX_XLEN-1:0] alu_model(input alu_op_e op,
            input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        alu_model = '0;
        case (op)
            ADD:     alu_model = a + b;
            SUB:     alu_model = a - b;
            SLT:     alu_model[0] = $signed(a) < $signed(b);
            SLTU:    alu_model[0] = a < b;
            AND:     alu_model = a & b;
            OR:      alu_model = a | b;
            NOR:     alu_model = ~(a | b);
            XOR:     alu_model = a ^ b;
            SLL:     alu_model = a << sh;
            SRL:     alu_model = a >> sh;
            SRA:     alu_model = $signed(a) >>> sh;
            LUI:     alu_model = b;
            default: alu_model = '0;
        endcase
    endfunction

    function automatic logic [`EX_XLEN-1:0] mul_model(input mul_op_e op,
            input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
        logic [2*`EX_XLEN-1:0] sprod;
        logic [2*`EX_XLEN-1:0] uprod;
        sprod = $signed({{`EX_XLEN{a[`EX_XLEN-1]}}, a})
              * $signed({{`EX_XLEN{b[`EX_XLEN-1]}}, b});
        uprod = {{`EX_XLEN{1'b0}}, a} * {{`EX_XLEN{1'b0}}, b};
        case (op)
            MUL_LO:  mul_model = uprod[`EX_XLEN-1:0];
            MUL_HI:  mul_model = sprod[2*`EX_XLEN-1:`EX_XLEN];
            default: mul_model = uprod[2*`EX_XLEN-1:`EX_XLEN];
        endcase
    endfunction

    function automatic logic [`EX_XLEN-1:0] div_model(input div_op_e op,
            input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
        logic                sgn;
        logic [`EX_XLEN-1:0] min_neg;
        logic [`EX_XLEN-1:0] q;
        logic [`EX_XLEN-1:0] r;
        sgn     = (op == DIV) || (op == MOD);
        min_neg = {1'b1, {(`EX_XLEN-1){1'b0}}};
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == min_neg && b == '1) begin
            q = min_neg;
            r = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);  // Truncating, sign of dividend
        end else begin
            q = a / b;
            r = a % b;
        end
        div_model = (op == MOD || op == MODU) ? r : q;
    endfunction

    task automatic check(input string name, input logic [`EX_XLEN-1:0] got,
            input logic [`EX_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("test failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic stop_on_error(input string what);
        $display("Error: %s", what);
        $display("test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic draw_instruction();
        int                  kind;
        int                  corner;
        logic [`EX_XLEN-1:0] bits;
        logic [`EX_XLEN-1:0] pc_val;
        logic [`EX_XLEN-1:0] a_val;
        logic [`EX_XLEN-1:0] b_val;
        logic                sel1;
        logic                sel2;
        div_op_e             dop;
        kind   = rand_below(3);
        corner = rand_below(8);
        bits   = $random(seed);
        pc_val = $random(seed);
        a_val  = pick_operand();
        b_val  = pick_operand();
        sel1   = bits[0];
        sel2   = bits[1];
        dop    = div_op_e'(2'(rand_below(4)));
        if (kind == 2 && corner == 0) begin
            sel2  = 1'b0;  // Zero divisor
            b_val = '0;
        end else if (kind == 2 && corner == 1) begin
            sel1  = 1'b0;
            sel2  = 1'b0;
            a_val = {1'b1, {(`EX_XLEN-1){1'b0}}};
            b_val = '1;
            dop   = bits[2] ? DIV : MOD;
        end
        in_valid    <= 1'b1;
        pc          <= {pc_val[`EX_XLEN-1:2], 2'b00};
        imm         <= pick_operand();
        rj_value    <= a_val;
        rkd_value   <= b_val;
        unit        <= ex_unit_e'(2'(kind));
        alu_op      <= alu_op_e'(4'(rand_below(12)));
        mul_op      <= mul_op_e'(2'(rand_below(3)));
        div_op      <= dop;
        src1_is_pc  <= sel1;
        src2_is_imm <= sel2;
        dest        <= bits[`EX_REG_W+7:8];
        gr_we       <= bits[3];
        mem_we      <= bits[4];
        mem_load    <= bits[5];
    endtask

    task automatic record_expected();
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] b;
        logic [`EX_XLEN-1:0] r;
        a = src1_is_pc ? pc : rj_value;
        b = src2_is_imm ? imm : rkd_value;
        case (unit)
            UNIT_MUL: r = mul_model(mul_op, a, b);
            UNIT_DIV: r = div_model(div_op, a, b);
            default:  r = alu_model(alu_op, a, b);
        endcase
        exp_result.push_back(r);
        exp_pc.push_back(pc);
        exp_store.push_back(rkd_value);
        exp_dest.push_back(dest);
        exp_flags.push_back({gr_we, mem_we, mem_load});
    endtask

    task automatic compare_output();
        logic [2:0] flags;
        if (exp_result.size() == 0) begin
            stop_on_error("output handshake with no instruction outstanding");
        end else begin
            flags = exp_flags.pop_front();
            check("result_out", result_out, exp_result.pop_front());
            check("pc_out", pc_out, exp_pc.pop_front());
            check("store_data_out", store_data_out, exp_store.pop_front());
            check("dest_out", `EX_XLEN'(dest_out), `EX_XLEN'(exp_dest.pop_front()));
            check("gr_we_out", `EX_XLEN'(gr_we_out), `EX_XLEN'(flags[2]));
            check("mem_we_out", `EX_XLEN'(mem_we_out), `EX_XLEN'(flags[1]));
            check("mem_load_out", `EX_XLEN'(mem_load_out), `EX_XLEN'(flags[0]));
            checked++;
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        pc          = '0;
        imm         = '0;
        rj_value    = '0;
        rkd_value   = '0;
        unit        = UNIT_ALU;
        alu_op      = ADD;
        mul_op      = MUL_LO;
        div_op      = DIV;
        src1_is_pc  = 1'b0;
        src2_is_imm = 1'b0;
        dest        = '0;
        gr_we       = 1'b0;
        mem_we      = 1'b0;
        mem_load    = 1'b0;
        out_ready   = 1'b0;
        issued      = 0;
        checked     = 0;
        repeat (2) @(posedge clk);
        check("out_valid", `EX_XLEN'(out_valid), '0);
        check("pc_out", pc_out, `EX_RESET_PC);
        rst <= 1'b0;

        while (checked < NUM_INSTR) begin
            @(posedge clk);
            if (out_valid && out_ready) compare_output();
            if (in_valid && in_ready) begin
                record_expected();
                issued++;
            end
            // Fields stay put until the stage takes them
            if (!in_valid || in_ready) begin
                if (issued < NUM_INSTR && rand_below(4) != 0) draw_instruction();
                else in_valid <= 1'b0;
            end
            out_ready <= rand_below(4) != 0;
        end

        // Nothing may follow the last instruction
        out_ready <= 1'b1;
        repeat (8) begin
            @(posedge clk);
            if (out_valid && out_ready) stop_on_error("output beyond the last instruction");
        end

        $display("test passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout with %0d of %0d instructions checked", checked, NUM_INSTR);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== flist.f ====
+incdir+include
source/ex_op_pkg.sv
source/ex_ctrl_pkg.sv
source/ex_int_unit.sv
source/ex_divider.sv
source/ex_stage.sv
dv/ex_stage_tb.sv

// ==== include/ex_settings.svh ====
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Datapath word width
`define EX_XLEN 32

// Destination register index width
`define EX_REG_W 5

`define EX_RESET_PC 32'h1c000000

// One quotient bit per divider iteration
`define EX_DIV_STEPS `EX_XLEN

`endif

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module ex_stage_tb -f flist.f -o ex_stage_sim &&
./obj_dir/ex_stage_sim || exit 1

// ==== source/ex_ctrl_pkg.sv ====
package ex_ctrl_pkg;

    // Divider sequencing
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_BUSY = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

endpackage

// ==== source/ex_divider.sv ====
`timescale 1ns/1ns
`include "ex_settings.svh"

module ex_divider import ex_op_pkg::*, ex_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                div_req_valid,
    output logic                div_req_ready,
    input  div_op_e             div_op,
    input  logic [`EX_XLEN-1:0] dividend,
    input  logic [`EX_XLEN-1:0] divisor,
    output logic                div_done,
    input  logic                div_consume,
    output logic [`EX_XLEN-1:0] quotient_rem
);

    localparam int CNT_W = $clog2(`EX_DIV_STEPS + 1);

    div_state_e          state_q;
    logic [CNT_W-1:0]    step_cnt;
    logic                want_rem_q;
    logic                neg_quo_q;
    logic                neg_rem_q;
    logic                zero_q;
    logic [`EX_XLEN-1:0] quo_q;
    logic [`EX_XLEN-1:0] rem_q;
    logic [`EX_XLEN-1:0] dvs_q;
    logic [`EX_XLEN-1:0] result_q;

    logic                accept;
    logic                is_signed;
    logic                a_neg;
    logic                b_neg;
    logic [`EX_XLEN:0]   shifted;
    logic [`EX_XLEN:0]   trial;
    logic [`EX_XLEN-1:0] quo_fix;
    logic [`EX_XLEN-1:0] rem_fix;

    assign div_req_ready = (state_q == DIV_IDLE);
    assign div_done      = (state_q == DIV_DONE);
    assign quotient_rem  = result_q;
    assign accept        = div_req_valid & div_req_ready;

    assign is_signed = (div_op == DIV) || (div_op == MOD);
    assign a_neg     = is_signed & dividend[`EX_XLEN-1];
    assign b_neg     = is_signed & divisor[`EX_XLEN-1];

    // One restoring step
    assign shifted = {rem_q, quo_q[`EX_XLEN-1]};
    assign trial   = shifted - {1'b0, dvs_q};

    assign quo_fix = zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;  // Follows dividend sign

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= DIV_IDLE;
            step_cnt <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (accept) begin
                        state_q  <= DIV_BUSY;
                        step_cnt <= '0;
                    end
                end
                DIV_BUSY: begin
                    if (step_cnt == CNT_W'(`EX_DIV_STEPS)) state_q <= DIV_DONE;
                    else step_cnt <= step_cnt + 1'b1;
                end
                DIV_DONE: begin
                    if (div_consume) state_q <= DIV_IDLE;
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            want_rem_q <= (div_op == MOD) || (div_op == MODU);
            neg_quo_q  <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;
            zero_q     <= (divisor == '0);
            quo_q      <= a_neg ? -dividend : dividend;
            dvs_q      <= b_neg ? -divisor : divisor;
            rem_q      <= '0;
        end else if (state_q == DIV_BUSY) begin
            if (step_cnt == CNT_W'(`EX_DIV_STEPS)) begin
                result_q <= want_rem_q ? rem_fix : quo_fix;
            end else begin
                rem_q <= trial[`EX_XLEN] ? shifted[`EX_XLEN-1:0] : trial[`EX_XLEN-1:0];
                quo_q <= {quo_q[`EX_XLEN-2:0], ~trial[`EX_XLEN]};
            end
        end
    end

    a_consume_when_done: assert property (@(posedge clk) disable iff (rst)
        div_consume |-> div_done);

    // Stage never re-issues while a division is in flight
    a_req_only_idle: assert property (@(posedge clk) disable iff (rst)
        div_req_valid |-> state_q == DIV_IDLE);

endmodule

// ==== source/ex_int_unit.sv ====
`timescale 1ns/1ns
`include "ex_settings.svh"

module ex_int_unit import ex_op_pkg::*; (
    input  ex_unit_e             unit,
    input  alu_op_e              alu_op,
    input  mul_op_e              mul_op,
    input  logic [`EX_XLEN-1:0]  src1,
    input  logic [`EX_XLEN-1:0]  src2,
    output logic [`EX_XLEN-1:0]  int_result
);

    logic [`EX_XLEN-1:0]   alu_result;
    logic [4:0]            shamt;
    logic                  mul_signed;
    logic [`EX_XLEN:0]     mul_a;
    logic [`EX_XLEN:0]     mul_b;
    logic [2*`EX_XLEN+1:0] product_ext;
    logic [2*`EX_XLEN-1:0] product;
    logic [`EX_XLEN-1:0]   mul_result;

    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            ADD:     alu_result = src1 + src2;
            SUB:     alu_result = src1 - src2;
            SLT: begin
                alu_result = {{(`EX_XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            SLTU: begin
                alu_result = {{(`EX_XLEN-1){1'b0}}, src1 < src2};
            end
            AND:     alu_result = src1 & src2;
            OR:      alu_result = src1 | src2;
            NOR:     alu_result = ~(src1 | src2);
            XOR:     alu_result = src1 ^ src2;
            SLL:     alu_result = src1 << shamt;
            SRL:     alu_result = src1 >> shamt;
            SRA:     alu_result = $unsigned($signed(src1) >>> shamt);
            LUI:     alu_result = src2;
            default: alu_result = '0;
        endcase
    end

    // Extra top bit turns one signed multiplier into both flavours
    assign mul_signed = (mul_op != MUL_HIU);
    assign mul_a = {mul_signed & src1[`EX_XLEN-1], src1};
    assign mul_b = {mul_signed & src2[`EX_XLEN-1], src2};

    assign product_ext = $signed({{(`EX_XLEN+1){mul_a[`EX_XLEN]}}, mul_a})
                       * $signed({{(`EX_XLEN+1){mul_b[`EX_XLEN]}}, mul_b});
    assign product = product_ext[2*`EX_XLEN-1:0];

    always_comb begin
        case (mul_op)
            MUL_LO:  mul_result = product[`EX_XLEN-1:0];
            MUL_HI,
            MUL_HIU: mul_result = product[2*`EX_XLEN-1:`EX_XLEN];
            default: mul_result = '0;
        endcase
    end

    // Divide results come from the divider, not from here
    always_comb begin
        case (unit)
            UNIT_MUL: int_result = mul_result;
            default:  int_result = alu_result;
        endcase
    end

endmodule

// ==== source/ex_op_pkg.sv ====
package ex_op_pkg;

    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2
    } ex_unit_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLT  = 4'd2,
        SLTU = 4'd3,
        AND  = 4'd4,
        OR   = 4'd5,
        NOR  = 4'd6,
        XOR  = 4'd7,
        SLL  = 4'd8,
        SRL  = 4'd9,
        SRA  = 4'd10,
        LUI  = 4'd11  // Immediate arrives already shifted
    } alu_op_e;

    typedef enum logic [1:0] {
        MUL_LO  = 2'd0,
        MUL_HI  = 2'd1,
        MUL_HIU = 2'd2
    } mul_op_e;

    typedef enum logic [1:0] {
        DIV  = 2'd0,
        MOD  = 2'd1,
        DIVU = 2'd2,
        MODU = 2'd3
    } div_op_e;

endpackage

// ==== source/ex_stage.sv ====
`timescale 1ns/1ns
`include "ex_settings.svh"

module ex_stage import ex_op_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [`EX_XLEN-1:0]  pc,
    input  logic [`EX_XLEN-1:0]  imm,
    input  logic [`EX_XLEN-1:0]  rj_value,
    input  logic [`EX_XLEN-1:0]  rkd_value,
    input  ex_unit_e             unit,
    input  alu_op_e              alu_op,
    input  mul_op_e              mul_op,
    input  div_op_e              div_op,
    input  logic                 src1_is_pc,
    input  logic                 src2_is_imm,
    input  logic [`EX_REG_W-1:0] dest,
    input  logic                 gr_we,
    input  logic                 mem_we,
    input  logic                 mem_load,

    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [`EX_XLEN-1:0]  result_out,
    output logic [`EX_XLEN-1:0]  pc_out,
    output logic [`EX_XLEN-1:0]  store_data_out,
    output logic [`EX_REG_W-1:0] dest_out,
    output logic                 gr_we_out,
    output logic                 mem_we_out,
    output logic                 mem_load_out
);

    logic [`EX_XLEN-1:0] src1;
    logic [`EX_XLEN-1:0] src2;
    logic [`EX_XLEN-1:0] int_result;
    logic [`EX_XLEN-1:0] quotient_rem;
    logic [`EX_XLEN-1:0] result;
    logic                is_div;
    logic                div_started;
    logic                div_req_valid;
    logic                div_req_ready;
    logic                div_done;
    logic                div_consume;
    logic                ready_go;
    logic                advance;

    assign src1 = src1_is_pc  ? pc  : rj_value;
    assign src2 = src2_is_imm ? imm : rkd_value;

    assign is_div   = (unit == UNIT_DIV);
    assign ready_go = !is_div || div_done;
    assign advance  = in_valid & ready_go & out_ready;
    assign in_ready = ~rst & (~in_valid | ready_go & out_ready);

    assign div_req_valid = in_valid & is_div & ~div_started;
    assign div_consume   = advance & is_div;

    // Set once the divider has taken this instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            div_started <= 1'b0;
        end else if (div_consume) begin
            div_started <= 1'b0;
        end else if (div_req_valid && div_req_ready) begin
            div_started <= 1'b1;
        end
    end

    ex_int_unit u_int_unit (
        .unit       (unit),
        .alu_op     (alu_op),
        .mul_op     (mul_op),
        .src1       (src1),
        .src2       (src2),
        .int_result (int_result)
    );

    ex_divider u_divider (
        .clk           (clk),
        .rst           (rst),
        .div_req_valid (div_req_valid),
        .div_req_ready (div_req_ready),
        .div_op        (div_op),
        .dividend      (src1),
        .divisor       (src2),
        .div_done      (div_done),
        .div_consume   (div_consume),
        .quotient_rem  (quotient_rem)
    );

    assign result = is_div ? quotient_rem : int_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid    <= 1'b0;
            pc_out       <= `EX_RESET_PC;
            gr_we_out    <= 1'b0;
            mem_we_out   <= 1'b0;
            mem_load_out <= 1'b0;
        end else if (out_ready) begin
            out_valid <= in_valid & ready_go;
            if (advance) begin
                pc_out       <= pc;
                gr_we_out    <= gr_we;
                mem_we_out   <= mem_we;
                mem_load_out <= mem_load;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            result_out     <= result;
            store_data_out <= rkd_value;  // Store data is always rkd
            dest_out       <= dest;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(result_out) && $stable(pc_out)
            && $stable(store_data_out) && $stable(dest_out) && $stable(gr_we_out)
            && $stable(mem_we_out) && $stable(mem_load_out));

    // Upstream must hold the instruction until it is taken
    a_in_hold: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> $stable(pc) && $stable(imm) && $stable(rj_value)
            && $stable(rkd_value) && $stable(unit) && $stable(alu_op) && $stable(mul_op)
            && $stable(div_op) && $stable(src1_is_pc) && $stable(src2_is_imm)
            && $stable(dest) && $stable(gr_we) && $stable(mem_we) && $stable(mem_load));

endmodule
